/* gdiv.f */
hdl/gdiv_pkg.sv
hdl/gdiv_ctrl_if.sv
hdl/recip_seed.sv
hdl/gdiv_datapath.sv
hdl/gdiv_control.sv
hdl/quot_correct.sv
hdl/gdiv_top.sv
sim/gdiv_tb.sv

/* hdl/gdiv_control.sv */
`timescale 1ns/100ps

module gdiv_control (
   input  logic      clk,
   input  logic      reset,
   input  logic      start,
   output logic      busy,
   output logic      done,
   gdiv_ctrl_if.ctrl bus
);
   import gdiv_pkg::*;

   gdiv_state_t           state;
   gdiv_state_t           state_next;
   logic [ITER_CNT_W-1:0] iter_cnt;
   logic                  last_iter;

   // third N/D pair
   assign last_iter = (iter_cnt == ITER_CNT_W'(ITER_COUNT - 1));

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= IDLE;
         iter_cnt <= '0;
         done     <= 1'b0;
      end else begin
         state <= state_next;
         // quot is registered on the same edge
         done  <= (state == SEL);
         if (state == SEED_D)
            iter_cnt <= '0;
         else if (state == ITER_D)
            iter_cnt <= iter_cnt + 1'b1;
      end
   end

   // start only looked at in IDLE
   always_comb begin
      state_next = state;
      case (state)
         IDLE:    state_next = start ? SEED_N : IDLE;
         SEED_N:  state_next = SEED_D;
         SEED_D:  state_next = ITER_N;
         ITER_N:  state_next = ITER_D;
         ITER_D:  state_next = last_iter ? REM : ITER_N;
         REM:     state_next = SEL;
         SEL:     state_next = IDLE;
         default: state_next = IDLE;
      endcase
   end

   // falls on the edge that raises done
   assign busy = (state != IDLE);

   // one multiply per state
   always_comb begin
      bus.load_n     = 1'b0;
      bus.load_d     = 1'b0;
      bus.load_f     = 1'b0;
      bus.load_q     = 1'b0;
      bus.load_r     = 1'b0;
      bus.sel_mcand  = MC_N;
      bus.sel_mplier = MP_ZERO;
      bus.rem_mode   = 1'b0;
      case (state)
         IDLE: begin
            // operand capture
            bus.load_n = start;
            bus.load_d = start;
         end
         SEED_N: begin
            bus.sel_mcand  = MC_SEED;
            bus.sel_mplier = MP_N_IN;
            bus.load_n     = 1'b1;
         end
         SEED_D: begin
            bus.sel_mcand  = MC_SEED;
            bus.sel_mplier = MP_D_IN;
            bus.load_d     = 1'b1;
            bus.load_f     = 1'b1;
         end
         ITER_N: begin
            bus.sel_mcand  = MC_N;
            bus.sel_mplier = MP_F;
            bus.load_n     = 1'b1;
         end
         ITER_D: begin
            // new F follows every new D
            bus.sel_mcand  = MC_D;
            bus.sel_mplier = MP_F;
            bus.load_d     = 1'b1;
            bus.load_f     = 1'b1;
         end
         REM: begin
            bus.sel_mcand  = MC_Q;
            bus.sel_mplier = MP_D_IN;
            bus.rem_mode   = 1'b1;
            bus.load_r     = 1'b1;
         end
         SEL: begin
            bus.load_q = 1'b1;
         end
         default: begin
            bus.load_q = 1'b0;
         end
      endcase
   end

endmodule

/* hdl/gdiv_ctrl_if.sv */
`timescale 1ns/100ps

interface gdiv_ctrl_if;
   import gdiv_pkg::*;

   // register load strobes
   logic    load_n;
   logic    load_d;
   logic    load_f;
   logic    load_q;
   logic    load_r;
   // operand selects for the shared multiplier
   op_sel_t sel_mcand;
   op_sel_t sel_mplier;
   // remainder pass negates the product and adds n
   logic    rem_mode;

   modport ctrl (output load_n, load_d, load_f, load_q, load_r,
                 output sel_mcand, sel_mplier, rem_mode);

   modport dp (input load_n, load_d, load_f, load_q, load_r,
               input sel_mcand, sel_mplier, rem_mode);

endinterface

/* hdl/gdiv_datapath.sv */
`timescale 1ns/100ps

module gdiv_datapath (
   input  logic                            clk,
   input  logic                            reset,
   gdiv_ctrl_if.dp                         bus,
   input  gdiv_pkg::mant_t                 n,
   input  gdiv_pkg::mant_t                 d,
   input  gdiv_pkg::seed_t                 seed,
   output logic [gdiv_pkg::SEED_IDX_W-1:0] seed_idx,
   output gdiv_pkg::quot_t                 q_est,
   output gdiv_pkg::mant_t                 d_reg,
   output gdiv_pkg::prod_t                 rem
);
   import gdiv_pkg::*;

   mant_t n_reg;
   work_t n_work;
   work_t d_work;
   work_t iter_n;
   work_t iter_d;
   work_t fac;
   quot_t q_inc;
   work_t mcand;
   work_t mplier;
   prod_t pp_lo;
   prod_t pp_hi;
   prod_t row_a;
   prod_t row_b;
   prod_t row_c;
   prod_t cs_sum;
   prod_t cs_maj;
   prod_t cs_carry;
   prod_t prod_res;
   logic  capture;

   // both loads together only happen on the start edge in IDLE
   assign capture = bus.load_n & bus.load_d;

   // operands held for the seed and remainder passes
   always_ff @(posedge clk) begin
      if (capture) begin
         n_reg <= n;
         d_reg <= d;
      end
   end

   // 7 fraction bits after the hidden one
   assign seed_idx = d_reg[MANT_W-2 -: SEED_IDX_W];

   // inputs aligned to the work format
   assign n_work = work_t'(n_reg) << IN_SHIFT;
   assign d_work = work_t'(d_reg) << IN_SHIFT;

   // quotient estimate is N cut to 52 fraction bits
   assign q_est = iter_n[WORK_W-1 -: QUOT_W];
   // next ulp up for the remainder pass
   assign q_inc = q_est + quot_t'(1);

   always_comb begin
      mcand = iter_n;
      case (bus.sel_mcand)
         MC_N:    mcand = iter_n;
         MC_D:    mcand = iter_d;
         MC_Q:    mcand = work_t'(q_inc) << IN_SHIFT;
         MC_SEED: mcand = work_t'(seed) << SEED_SHIFT;
         default: mcand = iter_n;
      endcase
   end

   always_comb begin
      mplier = '0;
      case (bus.sel_mplier)
         MP_N_IN: mplier = n_work;
         MP_D_IN: mplier = d_work;
         MP_F:    mplier = fac;
         MP_ZERO: mplier = '0;
         default: mplier = '0;
      endcase
   end

   // partial-product rows for the low and high multiplier halves
   assign pp_lo = prod_t'(mcand) * prod_t'(mplier[MUL_SPLIT-1:0]);
   assign pp_hi = (prod_t'(mcand) * prod_t'(mplier[WORK_W-1:MUL_SPLIT])) << MUL_SPLIT;

   // remainder pass computes n - P as n + ~lo + ~hi + 2
   assign row_a = pp_lo ^ {PROD_W{bus.rem_mode}};
   assign row_b = pp_hi ^ {PROD_W{bus.rem_mode}};
   assign row_c = bus.rem_mode ? (prod_t'(n_reg) << REM_N_SHIFT) : '0;

   // 3:2 compressor
   assign cs_sum = row_a ^ row_b ^ row_c;
   assign cs_maj = (row_a & row_b) | (row_a & row_c) | (row_b & row_c);
   // free carry lsb takes one of the two +1s
   assign cs_carry = {cs_maj[PROD_W-2:0], bus.rem_mode};

   // carry-propagate adder whose cin takes the other +1
   assign prod_res = cs_sum + cs_carry + prod_t'(bus.rem_mode);

   // iteration registers drop the low product bits
   always_ff @(posedge clk) begin
      if (reset) begin
         iter_n <= '0;
         iter_d <= '0;
         fac    <= '0;
         rem    <= '0;
      end else begin
         if (bus.load_n && !capture)
            iter_n <= prod_res[WORK_FRAC+WORK_W-1:WORK_FRAC];
         if (bus.load_d && !capture)
            iter_d <= prod_res[WORK_FRAC+WORK_W-1:WORK_FRAC];
         // F = 2 - D - ulp by one's complement since D is below 2
         if (bus.load_f)
            fac <= {1'b0, ~prod_res[WORK_FRAC+WORK_W-2:WORK_FRAC]};
         // full width n - (q+1)d
         if (bus.load_r)
            rem <= prod_res;
      end
   end

endmodule

/* hdl/gdiv_pkg.sv */
package gdiv_pkg;

   // operand and datapath widths
   localparam int MANT_W = 53;
   localparam int WORK_W = 64;
   localparam int PROD_W = 128;
   localparam int QUOT_W = 54;
   localparam int SEED_IDX_W = 7;
   localparam int SEED_W = 10;

   // fixed schedule
   localparam int ITER_COUNT = 3;
   localparam int ITER_CNT_W = 2;
   localparam int LATENCY = 10;

   // 1.0 sits on bit 62 of the iteration registers
   localparam int WORK_FRAC = WORK_W - 2;
   // mantissa or quotient lsb lands on work bit 10
   localparam int IN_SHIFT = WORK_FRAC - (MANT_W - 1);
   // seed fraction lines up under the work binary point
   localparam int SEED_SHIFT = WORK_FRAC - SEED_W;
   // n and d alignment inside the 124-fraction-bit product
   localparam int REM_N_SHIFT = 2 * WORK_FRAC - (MANT_W - 1);
   localparam int REM_D_SHIFT = 2 * WORK_FRAC - 2 * (MANT_W - 1);
   // multiplier split into two partial-product rows
   localparam int MUL_SPLIT = WORK_W / 2;

   typedef logic [MANT_W-1:0] mant_t;
   typedef logic [WORK_W-1:0] work_t;
   typedef logic [PROD_W-1:0] prod_t;
   typedef logic [QUOT_W-1:0] quot_t;
   typedef logic [SEED_W-1:0] seed_t;
   typedef logic [1:0]        op_sel_t;

   // multiplicand sources
   localparam op_sel_t MC_N    = 2'd0;
   localparam op_sel_t MC_D    = 2'd1;
   localparam op_sel_t MC_Q    = 2'd2;
   localparam op_sel_t MC_SEED = 2'd3;

   // multiplier sources
   localparam op_sel_t MP_N_IN = 2'd0;
   localparam op_sel_t MP_D_IN = 2'd1;
   localparam op_sel_t MP_F    = 2'd2;
   localparam op_sel_t MP_ZERO = 2'd3;

   typedef enum logic [2:0] {
      IDLE, SEED_N, SEED_D, ITER_N, ITER_D, REM, SEL
   } gdiv_state_t;

endpackage

/* hdl/gdiv_top.sv */
`timescale 1ns/100ps

module gdiv_top (
   input  logic            clk,
   input  logic            reset,
   input  logic            start,
   input  gdiv_pkg::mant_t n,
   input  gdiv_pkg::mant_t d,
   output logic            busy,
   output logic            done,
   output gdiv_pkg::quot_t quot,
   output logic            inexact
);
   import gdiv_pkg::*;

   logic [SEED_IDX_W-1:0] seed_idx;
   seed_t                 seed;
   quot_t                 q_est;
   mant_t                 d_reg;
   prod_t                 rem;

   // loads and selects from controller to datapath
   gdiv_ctrl_if bus ();

   gdiv_control u_control (
      .clk   (clk),
      .reset (reset),
      .start (start),
      .busy  (busy),
      .done  (done),
      .bus   (bus)
   );

   gdiv_datapath u_datapath (
      .clk      (clk),
      .reset    (reset),
      .bus      (bus),
      .n        (n),
      .d        (d),
      .seed     (seed),
      .seed_idx (seed_idx),
      .q_est    (q_est),
      .d_reg    (d_reg),
      .rem      (rem)
   );

   // table indexed by the captured divisor
   recip_seed u_seed (
      .idx  (seed_idx),
      .seed (seed)
   );

   // result stage loaded in SEL
   quot_correct u_correct (
      .clk     (clk),
      .reset   (reset),
      .load    (bus.load_q),
      .q_est   (q_est),
      .d_reg   (d_reg),
      .rem     (rem),
      .quot    (quot),
      .inexact (inexact)
   );

endmodule

/* hdl/quot_correct.sv */
`timescale 1ns/100ps

module quot_correct (
   input  logic            clk,
   input  logic            reset,
   input  logic            load,
   input  gdiv_pkg::quot_t q_est,
   input  gdiv_pkg::mant_t d_reg,
   input  gdiv_pkg::prod_t rem,
   output gdiv_pkg::quot_t quot,
   output logic            inexact
);
   import gdiv_pkg::*;

   quot_t q_inc;
   prod_t rem_low;
   logic  rem_neg;
   quot_t q_sel;
   logic  inexact_sel;

   // estimate is never above the exact quotient, nor more than 1 ulp below
   assign q_inc = q_est + quot_t'(1);

   // sign of rem = n - (q_est+1)*d decides
   assign rem_neg = rem[PROD_W-1];

   // remainder of q_est itself at the same scale as rem
   assign rem_low = rem + (prod_t'(d_reg) << REM_D_SHIFT);

   always_comb begin
      if (!rem_neg) begin
         // q_est+1 still fits under n/d
         q_sel       = q_inc;
         inexact_sel = |rem;
      end else begin
         q_sel       = q_est;
         inexact_sel = |rem_low;
      end
   end

   // held until the next division completes
   always_ff @(posedge clk) begin
      if (reset) begin
         quot    <= '0;
         inexact <= 1'b0;
      end else if (load) begin
         quot    <= q_sel;
         inexact <= inexact_sel;
      end
   end

endmodule

/* hdl/recip_seed.sv */
`timescale 1ns/100ps

module recip_seed (
   input  logic [gdiv_pkg::SEED_IDX_W-1:0] idx,
   output gdiv_pkg::seed_t                 seed
);
   import gdiv_pkg::*;

   // one entry per divisor interval of width 1/128
   seed_t [0:(1 << SEED_IDX_W)-1] seed_rom;

   // floor(1024 / d_mid), d_mid = 1 + (i + 0.5)/128
   // value is seed/1024, always below 1/d_mid
   // msb always set since 1/d > 0.5
   assign seed_rom = {
      // idx 0..31
      10'd1020, 10'd1012, 10'd1004, 10'd996,  10'd989,  10'd981,  10'd974,  10'd967,
      10'd960,  10'd953,  10'd946,  10'd939,  10'd932,  10'd926,  10'd919,  10'd913,
      10'd907,  10'd900,  10'd894,  10'd888,  10'd882,  10'd876,  10'd870,  10'd865,
      10'd859,  10'd853,  10'd848,  10'd842,  10'd837,  10'd832,  10'd826,  10'd821,
      // idx 32..63
      10'd816,  10'd811,  10'd806,  10'd801,  10'd796,  10'd791,  10'd787,  10'd782,
      10'd777,  10'd773,  10'd768,  10'd764,  10'd759,  10'd755,  10'd751,  10'd746,
      10'd742,  10'd738,  10'd734,  10'd730,  10'd726,  10'd722,  10'd718,  10'd714,
      10'd710,  10'd706,  10'd702,  10'd699,  10'd695,  10'd691,  10'd688,  10'd684,
      // idx 64..95
      10'd680,  10'd677,  10'd673,  10'd670,  10'd667,  10'd663,  10'd660,  10'd657,
      10'd653,  10'd650,  10'd647,  10'd644,  10'd640,  10'd637,  10'd634,  10'd631,
      10'd628,  10'd625,  10'd622,  10'd619,  10'd616,  10'd613,  10'd611,  10'd608,
      10'd605,  10'd602,  10'd599,  10'd597,  10'd594,  10'd591,  10'd589,  10'd586,
      // idx 96..127
      10'd583,  10'd581,  10'd578,  10'd576,  10'd573,  10'd571,  10'd568,  10'd566,
      10'd563,  10'd561,  10'd558,  10'd556,  10'd554,  10'd551,  10'd549,  10'd547,
      10'd544,  10'd542,  10'd540,  10'd538,  10'd536,  10'd533,  10'd531,  10'd529,
      10'd527,  10'd525,  10'd523,  10'd521,  10'd519,  10'd517,  10'd515,  10'd513
   };

   // purely combinational lookup
   assign seed = seed_rom[idx];

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=gdiv_tb
LOG=sim.log

verilator --binary --timing --top-module "$TOP" -f gdiv.f -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

# the testbench prints the fail message on any failure
if grep -q "Some tests failed" "$LOG"; then
   echo "simulation reported failures, see $LOG"
   exit 1
fi

echo "simulation finished without failures"
exit 0

/* sim/gdiv_tb.sv */
`timescale 1ns/100ps

module gdiv_tb;
   import gdiv_pkg::*;

   logic  clk;
   logic  reset;
   logic  start;
   mant_t n;
   mant_t d;
   logic  busy;
   logic  done;
   quot_t quot;
   logic  inexact;

   // vectors from the data file
   mant_t vec_n[$];
   mant_t vec_d[$];
   quot_t vec_q[$];
   logic  vec_x[$];

   integer seed = 32'hef5f;
   int     err_count = 0;
   int     pass_count = 0;
   int     fail_count = 0;
   int     cycle_cnt = 0;
   int     cycle_limit = 0;

   gdiv_top UUT (
      .clk     (clk),
      .reset   (reset),
      .start   (start),
      .n       (n),
      .d       (d),
      .busy    (busy),
      .done    (done),
      .quot    (quot),
      .inexact (inexact)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // watchdog armed once the vector count is known
   always @(posedge clk) begin
      if (!reset && cycle_limit > 0) begin
         cycle_cnt = cycle_cnt + 1;
         if (cycle_cnt >= cycle_limit) begin
            $display("simulation timed out waiting for done after %0d cycles", cycle_cnt);
            $display("Some tests failed");
            $finish;
         end
      end
   end

   task compare_value(input string name, input logic [63:0] expected,
                      input logic [63:0] actual);
      if (actual !== expected) begin
         $display("Fail at %0d ns: %s expected %h got %h", $time, name, expected, actual);
         err_count++;
      end
   endtask

   task report_test(input string label, input int errs_at_start);
      if (err_count == errs_at_start) begin
         pass_count++;
         $display("%s: passed", label);
      end else begin
         fail_count++;
         $display("%s: FAILED with %0d errors", label, err_count - errs_at_start);
      end
   endtask

   task load_vectors(output bit ok);
      int          fd;
      int          code;
      string       line;
      logic [63:0] f_n;
      logic [63:0] f_d;
      logic [63:0] f_q;
      logic [63:0] f_x;
      ok = 1'b0;
      fd = $fopen("sim/gdiv_testdata.txt", "r");
      if (fd == 0) begin
         $display("could not open sim/gdiv_testdata.txt");
      end else begin
         while (!$feof(fd)) begin
            code = $fgets(line, fd);
            // skip comment lines
            if (code > 0 && line.getc(0) != "#") begin
               code = $sscanf(line, "%h %h %h %h", f_n, f_d, f_q, f_x);
               if (code == 4) begin
                  vec_n.push_back(f_n[MANT_W-1:0]);
                  vec_d.push_back(f_d[MANT_W-1:0]);
                  vec_q.push_back(f_q[QUOT_W-1:0]);
                  vec_x.push_back(f_x[0]);
               end
            end
         end
         $fclose(fd);
         ok = (vec_n.size() > 0);
         if (!ok)
            $display("no vectors found in sim/gdiv_testdata.txt");
      end
   endtask

   // one division with an optional second start pulse while busy
   task run_division(input int idx, input bit intrude);
      int lat;
      bit got_done;
      lat = 0;
      got_done = 1'b0;
      @(posedge clk);
      start <= 1'b1;
      n     <= vec_n[idx];
      d     <= vec_d[idx];
      @(posedge clk);
      start <= 1'b0;
      // scramble the pins once the operands are captured
      n     <= vec_d[idx];
      d     <= vec_n[idx];
      while (!got_done) begin
         if (intrude && lat == 3) begin
            @(posedge clk);
            start <= 1'b1;
            n     <= 53'h1FFFFFFFFFFFFF;
            d     <= 53'h10000000000001;
         end else if (intrude && lat == 4) begin
            @(posedge clk);
            start <= 1'b0;
         end
         @(negedge clk);
         if (done) begin
            got_done = 1'b1;
         end else begin
            compare_value("busy", 64'(1'b1), 64'(busy));
            lat++;
         end
      end
      compare_value("latency", 64'(LATENCY), 64'(lat));
      // busy drops with done
      compare_value("busy", 64'(1'b0), 64'(busy));
      compare_value("quot", 64'(vec_q[idx]), 64'(quot));
      compare_value("inexact", 64'(vec_x[idx]), 64'(inexact));
   endtask

   initial begin
      bit ok;
      int errs;
      int gap;
      int i;
      int last;
      reset = 1'b1;
      start = 1'b0;
      n     = '0;
      d     = '0;
      load_vectors(ok);
      // each run is start, latency and a short idle gap
      if (ok)
         cycle_limit = (vec_n.size() + 2) * (LATENCY + 4) + 50;
      else
         fail_count++;
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      if (ok) begin
         // outputs idle before any start
         errs = err_count;
         repeat (2) @(negedge clk);
         compare_value("busy", 64'(1'b0), 64'(busy));
         compare_value("done", 64'(1'b0), 64'(done));
         compare_value("quot", 64'(0), 64'(quot));
         compare_value("inexact", 64'(1'b0), 64'(inexact));
         report_test("test 0: state after reset", errs);
         for (i = 0; i < vec_n.size(); i++) begin
            errs = err_count;
            run_division(i, 1'b0);
            report_test($sformatf("test %0d: n=%h d=%h quot=%h inexact=%b", i + 1,
                                  vec_n[i], vec_d[i], vec_q[i], vec_x[i]), errs);
            gap = int'($unsigned($random(seed)) % 32'd4);
            repeat (gap) @(posedge clk);
         end
         // last vector rerun with a second start while busy
         last = vec_n.size() - 1;
         errs = err_count;
         run_division(last, 1'b1);
         repeat (LATENCY + 2) begin
            @(negedge clk);
            compare_value("done", 64'(1'b0), 64'(done));
            compare_value("busy", 64'(1'b0), 64'(busy));
         end
         compare_value("quot", 64'(vec_q[last]), 64'(quot));
         report_test($sformatf("test %0d: start while busy", vec_n.size() + 1), errs);
      end
      $display("summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
      if (fail_count == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

/* sim/gdiv_testdata.txt */
# columns: n d quot inexact, all hex, n and d are 53-bit mantissas in [1,2)
# quot = floor(n * 2^52 / d), inexact = 1 when n * 2^52 mod d is non-zero
10000000000000 10000000000000 10000000000000 0
18000000000000 18000000000000 10000000000000 0
1C000000000000 1C000000000000 10000000000000 0
18000000000000 10000000000000 18000000000000 0
1E000000000000 14000000000000 18000000000000 0
12000000000000 18000000000000 0C000000000000 0
1ABCDEF0123456 1ABCDEF0123456 10000000000000 0
13579BDF02468A 13579BDF02468A 10000000000000 0
10000000000001 10000000000000 10000000000001 0
1FFFFFFFFFFFFF 10000000000000 1FFFFFFFFFFFFF 0
1FFFFFFFFFFFFF 1FFFFFFFFFFFFF 10000000000000 0
18000000000003 18000000000000 10000000000002 0
10000000000000 1FFFFFFFFFFFFF 08000000000000 1
10000000000001 1FFFFFFFFFFFFF 08000000000000 1
1FFFFFFFFFFFFE 1FFFFFFFFFFFFF 0FFFFFFFFFFFFF 1
10000000000000 10000000000001 0FFFFFFFFFFFFF 1
1FFFFFFFFFFFFF 10000000000001 1FFFFFFFFFFFFD 1
18000000000001 18000000000000 10000000000000 1
10000000000000 18000000000000 0AAAAAAAAAAAAA 1
10000000000000 14000000000000 0CCCCCCCCCCCCC 1
10000000000000 1C000000000000 09249249249249 1
10000000000000 12000000000000 0E38E38E38E38E 1
10000000000000 1E000000000000 08888888888888 1
10000000000000 11000000000000 0F0F0F0F0F0F0F 1
10000000000000 16000000000000 0BA2E8BA2E8BA2 1
18000000000000 14000000000000 13333333333333 1
1C000000000000 18000000000000 12AAAAAAAAAAAA 1
1FFFFFFFFFFFFF 18000000000000 15555555555554 1
14000000000000 1E000000000000 0AAAAAAAAAAAAA 1
18000000000000 1C000000000000 0DB6DB6DB6DB6D 1
1FFFFFFFFFFFFF 1C000000000000 12492492492491 1
